/* hdl/pid_settings.svh */
`ifndef PID_SETTINGS_SVH
`define PID_SETTINGS_SVH

////////////////////////////////////////////////////////////
// datapath widths
////////////////////////////////////////////////////////////

`define PID_W_ADC           16  // raw adc sample
`define PID_OS_LOG2         3   // 8 samples per block
`define PID_W_IN            18  // filtered sample
`define PID_W_EP            16  // host word, coefficients
`define PID_W_OUT           48  // pid accumulator, wide to keep clear of the rails
`define PID_W_DAC           16  // dac word
`define PID_COMP_LATENCY    1   // cycles spent in compute state

////////////////////////////////////////////////////////////
// host register map
////////////////////////////////////////////////////////////

`define PID_ADDR_SETPOINT   3'd0
`define PID_ADDR_P          3'd1
`define PID_ADDR_I          3'd2
`define PID_ADDR_D          3'd3
`define PID_ADDR_SHIFT      3'd4  // output shift, low 6 bits
`define PID_ADDR_CTRL       3'd5  // bit 0 is update enable
`define PID_ADDR_UPDATE     3'd6  // strobe only, data ignored
`define PID_ADDR_CLEAR      3'd7  // strobe only, data ignored

`endif

/* hdl/pid_pkg.sv */
`include "pid_settings.svh"

package pid_pkg;

	////////////////////////////////////////////////////////////
	// sample and output words
	////////////////////////////////////////////////////////////

	typedef logic signed [`PID_W_ADC-1:0] adc_sample_t;  // two's complement from adc
	typedef logic signed [`PID_W_IN-1:0]  filt_sample_t; // block average
	typedef logic signed [`PID_W_OUT-1:0] pid_out_t;     // full width control value
	typedef logic        [`PID_W_DAC-1:0] dac_word_t;    // offset binary

	////////////////////////////////////////////////////////////
	// host side
	////////////////////////////////////////////////////////////

	// one register write from the host
	typedef struct packed {
		logic [2:0]           addr; // see PID_ADDR_*
		logic [`PID_W_EP-1:0] data; // raw host word
	} host_wr_t;

	// loop parameters, staged and active copies share this layout
	typedef struct packed {
		logic signed [`PID_W_EP-1:0] setpoint; // lock point
		logic signed [`PID_W_EP-1:0] p;        // proportional
		logic signed [`PID_W_EP-1:0] i;        // integral
		logic signed [`PID_W_EP-1:0] d;        // derivative
	} pid_params_t;

endpackage

/* hdl/oversample_filter.sv */
`timescale 1ns/10ps
`include "pid_settings.svh"

module oversample_filter (
	input  logic                  clk_in,      // system clock
	input  logic                  reset_in,    // sync reset
	input  pid_pkg::adc_sample_t  adc_sample,  // raw sample
	input  logic                  adc_valid,   // sample strobe
	output pid_pkg::filt_sample_t filt_sample, // block average
	output logic                  filt_valid   // average strobe
);

	////////////////////////////////////////////////////////////
	// block accumulator
	////////////////////////////////////////////////////////////

	// sum of a full block needs OS_LOG2 extra bits
	localparam int W_ACC = `PID_W_ADC + `PID_OS_LOG2;

	logic [`PID_OS_LOG2-1:0] sample_cnt;  // position within block
	logic signed [W_ACC-1:0] acc;         // running block sum
	logic signed [W_ACC-1:0] acc_next;    // sum including current sample
	logic signed [W_ACC-1:0] avg;         // sum scaled back down
	logic                    last_sample; // closing sample of block

	assign acc_next    = acc + adc_sample;               // sign extended add
	assign avg         = acc_next >>> `PID_OS_LOG2;      // arithmetic divide by 8
	assign last_sample = adc_valid && (sample_cnt == '1); // counter wraps after this

	// count and sum, restart after each block
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			sample_cnt <= '0;
			acc        <= '0;
			filt_valid <= 1'b0;
		end else begin
			filt_valid <= last_sample; // one cycle after closing sample
			if (adc_valid) begin
				sample_cnt <= sample_cnt + 1'b1; // natural wrap at block end
				if (last_sample) begin
					acc <= '0;                 // fresh block
				end else begin
					acc <= acc_next;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// output register
	////////////////////////////////////////////////////////////

	// average of 16 bit samples fits easily in the filtered width
	always_ff @(posedge clk_in) begin
		if (last_sample) begin
			filt_sample <= avg[`PID_W_IN-1:0]; // top bit is only sign copy
		end
	end

endmodule

/* hdl/pid_param_bank.sv */
`timescale 1ns/10ps
`include "pid_settings.svh"

module pid_param_bank (
	input  logic                 clk_in,        // system clock
	input  logic                 reset_in,      // sync reset
	input  pid_pkg::host_wr_t    host_wr,       // address and data
	input  logic                 host_wr_valid, // write strobe
	output pid_pkg::pid_params_t staged_params, // waiting for update
	output logic [5:0]           out_shift,     // scaler shift amount
	output logic                 update_en,     // lets update through
	output logic                 update,        // copy staged to active
	output logic                 clear          // wipe pid history
);

	////////////////////////////////////////////////////////////
	// address decode
	////////////////////////////////////////////////////////////

	logic wr_update; // write hits update address
	logic wr_clear;  // write hits clear address

	assign wr_update = host_wr_valid && (host_wr.addr == `PID_ADDR_UPDATE);
	assign wr_clear  = host_wr_valid && (host_wr.addr == `PID_ADDR_CLEAR);

	////////////////////////////////////////////////////////////
	// staged registers
	////////////////////////////////////////////////////////////

	// all values land at the accepting edge
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			staged_params <= '0;
			out_shift     <= '0;
			update_en     <= 1'b0;
		end else if (host_wr_valid) begin
			case (host_wr.addr)
				`PID_ADDR_SETPOINT: staged_params.setpoint <= host_wr.data;
				`PID_ADDR_P:        staged_params.p        <= host_wr.data;
				`PID_ADDR_I:        staged_params.i        <= host_wr.data;
				`PID_ADDR_D:        staged_params.d        <= host_wr.data;
				`PID_ADDR_SHIFT:    out_shift              <= host_wr.data[5:0];
				`PID_ADDR_CTRL:     update_en              <= host_wr.data[0];
				default: ;                                 // update and clear are strobes
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// control strobes
	////////////////////////////////////////////////////////////

	// one cycle each, registered so the core sees them after the write edge
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			update <= 1'b0;
			clear  <= 1'b0;
		end else begin
			update <= wr_update;
			clear  <= wr_clear;
		end
	end

endmodule

/* hdl/pid_core.sv */
`timescale 1ns/10ps
`include "pid_settings.svh"

module pid_core (
	input  logic                  clk_in,        // system clock
	input  logic                  reset_in,      // sync reset
	input  pid_pkg::filt_sample_t filt_sample,   // averaged sample
	input  logic                  filt_valid,    // sample strobe
	input  pid_pkg::pid_params_t  staged_params, // from param bank
	input  logic                  update_en,     // gate for update
	input  logic                  update,        // load active params
	input  logic                  clear,         // zero history
	output pid_pkg::pid_out_t     pid_out,       // control value
	output logic                  pid_valid      // output strobe
);

	////////////////////////////////////////////////////////////
	// constants and state
	////////////////////////////////////////////////////////////

	localparam pid_pkg::pid_out_t MAX_OUTPUT = {1'b0, {(`PID_W_OUT-1){1'b1}}};
	localparam pid_pkg::pid_out_t MIN_OUTPUT = ~MAX_OUTPUT;
	localparam logic [7:0]        CNT_LAST   = 8'(`PID_COMP_LATENCY - 1);

	typedef enum logic [1:0] {
		ST_IDLE,    // wait for sample
		ST_COMPUTE, // products into delta register
		ST_SEND,    // sum and rail into output register
		ST_DONE     // shift history
	} state_t;

	state_t     state;      // current state
	state_t     next_state; // decoded next state
	logic [7:0] counter;    // cycles spent in compute

	////////////////////////////////////////////////////////////
	// datapath registers
	////////////////////////////////////////////////////////////

	pid_pkg::filt_sample_t       data;     // captured sample
	logic signed [`PID_W_EP-1:0] setpoint; // active setpoint
	logic signed [`PID_W_EP-1:0] p_coef;   // active p
	logic signed [`PID_W_EP-1:0] i_coef;   // active i
	logic signed [`PID_W_EP-1:0] d_coef;   // active d

	logic signed [`PID_W_IN:0]   e_cur;    // setpoint minus sample
	logic signed [`PID_W_IN:0]   e_prev_0; // e[n-1]
	logic signed [`PID_W_IN:0]   e_prev_1; // e[n-2]

	logic signed [`PID_W_EP+1:0] k1;       // p+i+d
	logic signed [`PID_W_EP+1:0] k2;       // -p-2d
	logic signed [`PID_W_EP+1:0] k3;       // d

	pid_pkg::pid_out_t delta_u; // velocity term
	pid_pkg::pid_out_t delta_q; // registered velocity term
	pid_pkg::pid_out_t u_prev;  // last output
	pid_pkg::pid_out_t u_cur;   // unrailed new output
	pid_pkg::pid_out_t u_rail;  // rail picked by old sign
	logic              overflow;

	////////////////////////////////////////////////////////////
	// arithmetic
	////////////////////////////////////////////////////////////

	assign e_cur = setpoint - data; // 19 bits, no wrap

	// z-form coefficients
	assign k1 = p_coef + i_coef + d_coef;
	assign k2 = -p_coef - (d_coef <<< 1);
	assign k3 = d_coef;

	// all signed, operands widen to the accumulator before multiply
	assign delta_u = k1 * e_cur + k2 * e_prev_0 + k3 * e_prev_1;
	assign u_cur   = u_prev + delta_q;

	// same sign in, different sign out
	assign overflow = (delta_q[`PID_W_OUT-1] == u_prev[`PID_W_OUT-1]) &&
		(u_cur[`PID_W_OUT-1] != u_prev[`PID_W_OUT-1]);
	assign u_rail   = u_prev[`PID_W_OUT-1] ? MIN_OUTPUT : MAX_OUTPUT;

	////////////////////////////////////////////////////////////
	// fsm
	////////////////////////////////////////////////////////////

	always_comb begin
		next_state = state;
		case (state)
			ST_IDLE:    if (filt_valid) next_state = ST_COMPUTE; // busy otherwise
			ST_COMPUTE: if (counter == CNT_LAST) next_state = ST_SEND;
			ST_SEND:    next_state = ST_DONE;
			ST_DONE:    next_state = ST_IDLE;
			default:    next_state = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			state   <= ST_IDLE;
			counter <= '0;
		end else begin
			state <= next_state;
			if (state != next_state) begin
				counter <= '0;          // restart on every transition
			end else if (state == ST_COMPUTE) begin
				counter <= counter + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// sequential datapath
	////////////////////////////////////////////////////////////

	// payload stages, loaded by state
	always_ff @(posedge clk_in) begin
		if ((state == ST_IDLE) && filt_valid) begin
			data <= filt_sample;     // samples arriving while busy are lost
		end
		if (state == ST_COMPUTE) begin
			delta_q <= delta_u;
		end
		if (state == ST_SEND) begin
			pid_out <= overflow ? u_rail : u_cur; // held until next send
		end
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			pid_valid <= 1'b0;
		end else begin
			pid_valid <= (state == ST_SEND); // high during done
		end
	end

	// active parameters, only when host allows
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			setpoint <= '0;
			p_coef   <= '0;
			i_coef   <= '0;
			d_coef   <= '0;
		end else if (update && update_en) begin
			setpoint <= staged_params.setpoint;
			p_coef   <= staged_params.p;
			i_coef   <= staged_params.i;
			d_coef   <= staged_params.d;
		end
	end

	// error and output history
	always_ff @(posedge clk_in) begin
		if (reset_in || clear) begin
			u_prev   <= '0;
			e_prev_0 <= '0;
			e_prev_1 <= '0;
		end else if (state == ST_DONE) begin
			u_prev   <= pid_out;  // railed value, not raw sum
			e_prev_0 <= e_cur;
			e_prev_1 <= e_prev_0;
		end
	end

endmodule

/* hdl/output_scaler.sv */
`timescale 1ns/10ps
`include "pid_settings.svh"

module output_scaler (
	input  logic               clk_in,    // system clock
	input  logic               reset_in,  // sync reset
	input  pid_pkg::pid_out_t  pid_out,   // wide control value
	input  logic               pid_valid, // value strobe
	input  logic [5:0]         out_shift, // right shift amount
	output pid_pkg::dac_word_t dac_word,  // offset binary
	output logic               dac_valid  // word strobe
);

	////////////////////////////////////////////////////////////
	// shift and clamp
	////////////////////////////////////////////////////////////

	localparam logic signed [`PID_W_DAC-1:0] DAC_MAX = {1'b0, {(`PID_W_DAC-1){1'b1}}};
	localparam logic signed [`PID_W_DAC-1:0] DAC_MIN = ~DAC_MAX;

	pid_pkg::pid_out_t            shifted;     // scaled control value
	logic [`PID_W_OUT-`PID_W_DAC-1:0] upper;   // bits above the dac sign
	logic                         clip_hi;     // beyond positive range
	logic                         clip_lo;     // beyond negative range
	logic signed [`PID_W_DAC-1:0] clamped;     // two's complement dac value

	assign shifted = pid_out >>> out_shift; // keeps sign
	assign upper   = shifted[`PID_W_OUT-2:`PID_W_DAC-1];

	// in range only when every upper bit copies the sign
	assign clip_hi = !shifted[`PID_W_OUT-1] && (|upper);
	assign clip_lo = shifted[`PID_W_OUT-1] && !(&upper);

	always_comb begin
		if (clip_hi) begin
			clamped = DAC_MAX;
		end else if (clip_lo) begin
			clamped = DAC_MIN;
		end else begin
			clamped = shifted[`PID_W_DAC-1:0];
		end
	end

	////////////////////////////////////////////////////////////
	// output register
	////////////////////////////////////////////////////////////

	// sign flip gives offset binary, zero lands mid scale
	always_ff @(posedge clk_in) begin
		if (pid_valid) begin
			dac_word <= {~clamped[`PID_W_DAC-1], clamped[`PID_W_DAC-2:0]};
		end
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			dac_valid <= 1'b0;
		end else begin
			dac_valid <= pid_valid; // one cycle behind
		end
	end

endmodule

/* hdl/pid_lock_top.sv */
`timescale 1ns/10ps

module pid_lock_top (
	input  logic               clk_in,        // system clock
	input  logic               reset_in,      // sync reset
	input  pid_pkg::adc_sample_t adc_sample,  // raw adc data
	input  logic               adc_valid,     // adc strobe
	input  pid_pkg::host_wr_t  host_wr,       // host register write
	input  logic               host_wr_valid, // host strobe
	output pid_pkg::dac_word_t dac_word,      // to dac serializer
	output logic               dac_valid,     // dac strobe
	output pid_pkg::pid_out_t  pid_out,       // wide output, for source mux
	output logic               pid_valid      // pid strobe
);

	////////////////////////////////////////////////////////////
	// internal nets
	////////////////////////////////////////////////////////////

	pid_pkg::filt_sample_t filt_sample;   // filter to core
	logic                  filt_valid;
	pid_pkg::pid_params_t  staged_params; // bank to core
	logic                  update_en;
	logic                  update;
	logic                  clear;
	logic [5:0]            out_shift;     // bank to scaler

	////////////////////////////////////////////////////////////
	// blocks
	////////////////////////////////////////////////////////////

	oversample_filter filter0 (
		.clk_in      (clk_in),
		.reset_in    (reset_in),
		.adc_sample  (adc_sample),
		.adc_valid   (adc_valid),
		.filt_sample (filt_sample),
		.filt_valid  (filt_valid)
	);

	pid_param_bank bank0 (
		.clk_in        (clk_in),
		.reset_in      (reset_in),
		.host_wr       (host_wr),
		.host_wr_valid (host_wr_valid),
		.staged_params (staged_params),
		.out_shift     (out_shift),
		.update_en     (update_en),
		.update        (update),
		.clear         (clear)
	);

	pid_core core0 (
		.clk_in        (clk_in),
		.reset_in      (reset_in),
		.filt_sample   (filt_sample),
		.filt_valid    (filt_valid),
		.staged_params (staged_params),
		.update_en     (update_en),
		.update        (update),
		.clear         (clear),
		.pid_out       (pid_out),
		.pid_valid     (pid_valid)
	);

	output_scaler scaler0 (
		.clk_in    (clk_in),
		.reset_in  (reset_in),
		.pid_out   (pid_out),
		.pid_valid (pid_valid),
		.out_shift (out_shift),
		.dac_word  (dac_word),
		.dac_valid (dac_valid)
	);

endmodule

/* test/pid_lock_tb.sv */
`timescale 1ns/10ps
`include "pid_settings.svh"

module pid_lock_tb;

	////////////////////////////////////////////////////////////
	// limits and signals
	////////////////////////////////////////////////////////////

	localparam int     BLK         = 1 << `PID_OS_LOG2;  // samples per block
	localparam int     SAT_BLOCKS  = 65544;              // crosses the positive rail
	localparam int     ALL_BLOCKS  = 1 + 6 + 8 + 5 + SAT_BLOCKS + 2 + 3;
	localparam int     CYCLE_LIMIT = ALL_BLOCKS * 16 + 16 + 1000; // blocks, reset, host writes
	localparam int     STROBE_WAIT = 16;                 // cycles per strobe
	localparam longint OUT_MAX     = (longint'(1) <<< (`PID_W_OUT - 1)) - 1;
	localparam longint OUT_MIN     = -(longint'(1) <<< (`PID_W_OUT - 1));
	localparam longint DAC_HI      = (longint'(1) <<< (`PID_W_DAC - 1)) - 1;
	localparam longint DAC_LO      = -(longint'(1) <<< (`PID_W_DAC - 1));

	logic                  clk_in, reset_in, adc_valid, host_wr_valid, dac_valid, pid_valid;
	pid_pkg::adc_sample_t  adc_sample;
	pid_pkg::host_wr_t     host_wr;
	pid_pkg::dac_word_t    dac_word;
	pid_pkg::pid_out_t     pid_out;

	pid_pkg::adc_sample_t  blk [BLK];                   // next block to push
	logic [31:0]           lfsr;                        // galois state
	longint                m_u, m_e1, m_e2;             // model history
	longint                m_sp, m_p, m_i, m_d;         // model active params
	longint                st_sp, st_p, st_i, st_d;     // model staged params
	bit                    m_en;                        // model update enable
	int                    m_shift;                     // model output shift
	pid_pkg::dac_word_t    exp_dac;                     // predicted dac word
	int                    last_latency, err_cnt, chk_cnt, test_cnt, cycle_cnt;

	pid_lock_top dut0 (
		.clk_in(clk_in), .reset_in(reset_in), .adc_sample(adc_sample), .adc_valid(adc_valid),
		.host_wr(host_wr), .host_wr_valid(host_wr_valid), .dac_word(dac_word),
		.dac_valid(dac_valid), .pid_out(pid_out), .pid_valid(pid_valid)
	);

	initial begin
		clk_in = 1'b0;
		forever #20 clk_in = ~clk_in; // 40 ns period
	end

	// hard stop if a test hangs
	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < CYCLE_LIMIT) begin
			@(posedge clk_in);
			cycle_cnt++;
		end
		$display("run stopped: the tests did not finish within %0d clock cycles", CYCLE_LIMIT);
		$display("ERRORS FOUND");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int k = 0; k < n; k++) begin
			r    = {r[30:0], lfsr[0]};                                     // one step per bit
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1); // x^32+x^22+x^2+x+1
		end
		return r;
	endfunction

	task automatic fill_random();
		for (int k = 0; k < BLK; k++) begin
			blk[k] = pid_pkg::adc_sample_t'(rand_bits(`PID_W_ADC));
		end
	endtask

	task automatic fill_const(input pid_pkg::adc_sample_t v);
		for (int k = 0; k < BLK; k++) begin
			blk[k] = v;
		end
	endtask

	task automatic push_block(); // back to back samples, then one idle cycle
		for (int k = 0; k < BLK; k++) begin
			@(negedge clk_in);
			adc_sample = blk[k];
			adc_valid  = 1'b1;
		end
		@(negedge clk_in);
		adc_valid  = 1'b0;
		adc_sample = '0;
	endtask

	// drives the bus and keeps the model's register copy in step
	task automatic host_write(input logic [2:0] addr, input logic [`PID_W_EP-1:0] data);
		@(negedge clk_in);
		host_wr.addr  = addr;
		host_wr.data  = data;
		host_wr_valid = 1'b1;
		@(negedge clk_in);
		host_wr_valid = 1'b0;
		case (addr)
			`PID_ADDR_SETPOINT: st_sp = longint'($signed(data));
			`PID_ADDR_P:        st_p  = longint'($signed(data));
			`PID_ADDR_I:        st_i  = longint'($signed(data));
			`PID_ADDR_D:        st_d  = longint'($signed(data));
			`PID_ADDR_SHIFT:    m_shift = int'(data[5:0]);
			`PID_ADDR_CTRL:     m_en  = data[0];
			`PID_ADDR_UPDATE: begin
				if (m_en) begin
					m_sp = st_sp;
					m_p  = st_p;
					m_i  = st_i;
					m_d  = st_d;
				end
			end
			default: begin                                 // clear
				m_u  = 0;
				m_e1 = 0;
				m_e2 = 0;
			end
		endcase
	endtask

	task automatic set_params(input logic [15:0] sp, p, i, d); // stage, enable, apply
		host_write(`PID_ADDR_SETPOINT, sp);
		host_write(`PID_ADDR_P, p);
		host_write(`PID_ADDR_I, i);
		host_write(`PID_ADDR_D, d);
		host_write(`PID_ADDR_CTRL, 16'd1);
		host_write(`PID_ADDR_UPDATE, '0);
	endtask

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////

	function automatic pid_pkg::dac_word_t scale_dac(input longint u, input int shift);
		longint      s;
		logic [15:0] w;
		s = u >>> shift;
		if (s > DAC_HI) s = DAC_HI;                 // clamp to signed dac range
		else if (s < DAC_LO) s = DAC_LO;
		w = s[15:0];
		return {~w[15], w[14:0]};                   // offset binary
	endfunction

	task automatic model_block();
		longint sum;
		longint e;
		longint u;
		sum = 0;
		for (int k = 0; k < BLK; k++) begin
			sum += longint'(blk[k]);
		end
		e = m_sp - (sum >>> `PID_OS_LOG2);          // floor mean
		u = m_u + (m_p + m_i + m_d) * e - (m_p + 2 * m_d) * m_e1 + m_d * m_e2;
		if (u > OUT_MAX || u < OUT_MIN) begin
			u = (m_u < 0) ? OUT_MIN : OUT_MAX;       // rail keeps old sign
		end
		m_e2    = m_e1;
		m_e1    = e;
		m_u     = u;
		exp_dac = scale_dac(m_u, m_shift);
	endtask

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	task automatic check_pid(input pid_pkg::pid_out_t got, exp, input string what);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("error at %0t ns: %s, pid_out %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_dac(input pid_pkg::dac_word_t got, exp, input string what);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("error at %0t ns: %s, dac_word %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_latency(input int got, exp, input string what);
		chk_cnt++;
		if (got != exp) begin
			err_cnt++;
			$display("error at %0t ns: %s, latency %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic wait_valid(input bit want_dac, output int cycles, output bit seen);
		cycles = 0;
		seen   = 1'b0;
		while (!seen && cycles < STROBE_WAIT) begin
			@(negedge clk_in);                         // outputs settled here
			cycles++;
			seen = want_dac ? dac_valid : pid_valid;
		end
		if (!seen) begin
			err_cnt++;
			$display("%s never came within %0d cycles of the block",
				want_dac ? "dac_valid" : "pid_valid", STROBE_WAIT);
		end
	endtask

	// latency counts edges from the one accepting the last sample
	task automatic run_block(input string what);
		int t_pid;
		int t_dac;
		bit seen;
		push_block();
		model_block();
		wait_valid(1'b0, t_pid, seen);
		if (seen) check_pid(pid_out, pid_pkg::pid_out_t'(m_u), what);
		wait_valid(1'b1, t_dac, seen);
		if (seen) check_dac(dac_word, exp_dac, what);
		last_latency = t_pid + t_dac;
	endtask

	task automatic end_test(input string name, input int errs_before);
		test_cnt++;
		if (err_cnt == errs_before) $display("%s: ok", name);
		else $display("%s: %0d errors", name, err_cnt - errs_before);
	endtask

	////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////

	task automatic test_reset();
		int e0;
		e0 = err_cnt;
		if (pid_valid !== 1'b0 || dac_valid !== 1'b0) begin
			err_cnt++;
			$display("an output strobe was not low after reset");
		end
		fill_random();
		run_block("first block after reset");
		check_pid(pid_out, '0, "zero parameters");
		check_dac(dac_word, 16'h8000, "mid scale");
		end_test("reset state", e0);
	endtask

	task automatic test_prop();
		int e0;
		e0 = err_cnt;
		set_params(16'sd1024, 16'sd7, 16'sd0, 16'sd0);
		host_write(`PID_ADDR_SHIFT, 16'd6);
		for (int k = 0; k < 6; k++) begin
			fill_random();
			run_block("proportional block");
		end
		end_test("averaging and proportional gain", e0);
	endtask

	task automatic test_int_deriv();
		int e0;
		e0 = err_cnt;
		host_write(`PID_ADDR_CLEAR, '0);
		set_params(-16'sd500, 16'sd3, 16'sd2, 16'sd5);
		host_write(`PID_ADDR_SHIFT, 16'd2);
		for (int k = 0; k < 8; k++) begin
			if (k < 3) fill_const(16'sd1000);         // settle
			else if (k < 6) fill_const(-16'sd2000);   // step
			else fill_random();
			run_block("integral and derivative block");
		end
		end_test("integral and derivative", e0);
	endtask

	task automatic test_gating();
		int                e0;
		pid_pkg::pid_out_t held;
		e0 = err_cnt;
		host_write(`PID_ADDR_CLEAR, '0);
		set_params(16'sd200, 16'sd40, 16'sd0, 16'sd0);
		fill_const(16'sd100);
		run_block("before gated writes");
		held = pid_pkg::pid_out_t'(m_u);           // predicted level to hold
		host_write(`PID_ADDR_CTRL, 16'd0);
		host_write(`PID_ADDR_P, 16'd900);
		host_write(`PID_ADDR_I, 16'd50);
		host_write(`PID_ADDR_UPDATE, '0);          // blocked by update_en
		for (int k = 0; k < 2; k++) begin
			run_block("gated update");
			check_pid(pid_out, held, "output held while gated");
		end
		host_write(`PID_ADDR_CTRL, 16'd1);
		host_write(`PID_ADDR_UPDATE, '0);
		run_block("update applied");
		host_write(`PID_ADDR_CLEAR, '0);
		run_block("after clear");
		check_pid(pid_out, pid_pkg::pid_out_t'(950 * 100), "first step after clear"); // k1*e
		end_test("update gating and clear", e0);
	endtask

	task automatic test_saturation();
		int e0;
		e0 = err_cnt;
		host_write(`PID_ADDR_CLEAR, '0);
		host_write(`PID_ADDR_SHIFT, 16'd0);
		set_params(16'sd32767, 16'sd0, 16'sd32767, 16'sd0);
		fill_const(16'sh8000);                     // most negative sample, largest error
		for (int k = 1; k < SAT_BLOCKS; k++) begin
			push_block();
			model_block();
		end
		run_block("last step toward rail");
		check_pid(pid_out, pid_pkg::pid_out_t'(OUT_MAX), "positive rail");
		check_dac(dac_word, 16'hFFFF, "clamp high");
		host_write(`PID_ADDR_CLEAR, '0);
		set_params(16'sd0, 16'sd1000, 16'sd0, 16'sd0);
		fill_const(16'sd20000);
		run_block("large negative step");
		check_dac(dac_word, 16'h0000, "clamp low");
		host_write(`PID_ADDR_SHIFT, 16'd16);
		run_block("shifted into range");
		end_test("saturation", e0);
	endtask

	task automatic test_latency();
		int e0;
		e0 = err_cnt;
		set_params(16'sd0, 16'sd5, 16'sd1, 16'sd2);
		host_write(`PID_ADDR_SHIFT, 16'd8);
		for (int k = 0; k < 3; k++) begin
			fill_random();
			run_block("latency block");
			check_latency(last_latency, `PID_COMP_LATENCY + 3, "last sample to dac_valid");
		end
		end_test("latency", e0);
	endtask

	initial begin
		adc_sample    = '0;
		adc_valid     = 1'b0;
		host_wr       = '0;
		host_wr_valid = 1'b0;
		reset_in      = 1'b1;
		lfsr          = 32'h58e0_4217;
		{m_u, m_e1, m_e2, m_sp, m_p, m_i, m_d} = '0;
		{st_sp, st_p, st_i, st_d} = '0;
		m_en          = 1'b0;
		m_shift       = 0;
		{err_cnt, chk_cnt, test_cnt, last_latency} = '0;
		repeat (16) @(posedge clk_in);
		@(negedge clk_in);
		reset_in = 1'b0;
		test_reset();
		test_prop();
		test_int_deriv();
		test_gating();
		test_saturation();
		test_latency();
		$display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

/* src.f */
+incdir+hdl
hdl/pid_pkg.sv
hdl/oversample_filter.sv
hdl/pid_param_bank.sv
hdl/pid_core.sv
hdl/output_scaler.sv
hdl/pid_lock_top.sv
test/pid_lock_tb.sv

/* Bender.yml */
package:
  name: pid_lock

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/pid_pkg.sv
      - hdl/oversample_filter.sv
      - hdl/pid_param_bank.sv
      - hdl/pid_core.sv
      - hdl/output_scaler.sv
      - hdl/pid_lock_top.sv
      - target: test
        files:
          - test/pid_lock_tb.sv
